// File: design/edma_consts.svh
/*
 * edma constants, address width fixed at 32 (the register file is 32 bits wide)
 * only the low AW bits of the 64-bit addresses advance during a transfer
 * register index is taken from dstaddr bits 6:2 of a config packet
 */
`ifndef EDMA_CONSTS_SVH
`define EDMA_CONSTS_SVH

// ####################
// packet geometry
`define EDMA_AW 32                  // address and data width
`define EDMA_PW (2*`EDMA_AW+40)     // emesh packet width, 104

// ####################
// register indices, dstaddr[6:2]
`define EDMA_CONFIG    5'd0
`define EDMA_STRIDE    5'd1
`define EDMA_COUNT     5'd2
`define EDMA_SRCADDR   5'd3
`define EDMA_SRCADDR64 5'd4
`define EDMA_DSTADDR   5'd5
`define EDMA_DSTADDR64 5'd6
`define EDMA_STATUS    5'd7

// config bits, the rest is reserved
`define EDMA_CFG_EN    0            // enable, cleared by hw at end
`define EDMA_CFG_IRQ   4            // irq at end of transfer
`define EDMA_CFG_DMODE 6:5          // transfer size

// master port credits
`define EDMA_CREDITS 4
`define EDMA_CRW     3              // wide enough for 0..EDMA_CREDITS

`endif

// File: design/edma_pkg.sv
/*
 * shared types for the dma, packet field order follows the emesh layout
 * (write in bit 0, srcaddr in the top AW bits)
 */
`include "edma_consts.svh"

package edma_pkg;

   // sequencer states, also shown in status[3:0]
   typedef enum logic [3:0] {
      IDLE   = 4'd0,
      ACTIVE = 4'd1,
      DRAIN  = 4'd2,   // abort, enable cleared mid transfer
      DONE   = 4'd3
   } dma_state_t;

   // register select
   typedef enum logic [4:0] {
      REG_CONFIG    = `EDMA_CONFIG,
      REG_STRIDE    = `EDMA_STRIDE,
      REG_COUNT     = `EDMA_COUNT,
      REG_SRCADDR   = `EDMA_SRCADDR,
      REG_SRCADDR64 = `EDMA_SRCADDR64,
      REG_DSTADDR   = `EDMA_DSTADDR,
      REG_DSTADDR64 = `EDMA_DSTADDR64,
      REG_STATUS    = `EDMA_STATUS
   } reg_sel_t;

   // emesh packet, msb first
   typedef struct packed {
      logic [`EDMA_AW-1:0] srcaddr;   // return address
      logic [`EDMA_AW-1:0] data;
      logic [`EDMA_AW-1:0] dstaddr;
      logic [4:0]          ctrlmode;
      logic [1:0]          datamode;
      logic                write;     // bit 0
   } emesh_packet_t;

endpackage

// File: design/edma_cfg_if.sv
/*
 * link between register file and engine
 * start and done are single-cycle pulses, update marks an issued request
 */
`timescale 1ns/1ps
`include "edma_consts.svh"

interface edma_cfg_if;
   import edma_pkg::*;

   // register file to engine
   logic                start;          // enable set while idle
   logic                enable;         // live config enable bit
   logic                irqmode;
   logic [1:0]          datamode;
   logic [`EDMA_AW-1:0] stride;
   logic [31:0]         count;
   logic [`EDMA_AW-1:0] srcaddr;
   logic [`EDMA_AW-1:0] dstaddr;

   // engine to register file
   logic                update;         // values after the step
   logic [31:0]         cur_count;
   logic [`EDMA_AW-1:0] cur_srcaddr;
   logic [`EDMA_AW-1:0] cur_dstaddr;
   dma_state_t          state;
   logic                done;           // clears enable

   modport regs (
      output start, enable, irqmode, datamode, stride, count, srcaddr, dstaddr,
      input  update, cur_count, cur_srcaddr, cur_dstaddr, state, done
   );

   modport engine (
      input  start, enable, irqmode, datamode, stride, count, srcaddr, dstaddr,
      output update, cur_count, cur_srcaddr, cur_dstaddr, state, done
   );

endinterface

// File: design/edma_regs.sv
/*
 * dma register file, never stalls, one readback per read packet a cycle later
 * processor writes win over engine write-back in the same cycle
 * unmapped indices read as zero
 */
`timescale 1ns/1ps
`include "edma_consts.svh"

module edma_regs (
   input  logic                    clk,
   input  logic                    nreset,
   input  logic                    reg_access_in,
   input  edma_pkg::emesh_packet_t reg_packet_in,
   output logic                    reg_access_out,
   output edma_pkg::emesh_packet_t reg_packet_out,
   edma_cfg_if.regs                cfg
);
   import edma_pkg::*;

   logic [31:0] config_reg;
   logic [31:0] stride_reg;
   logic [31:0] count_reg;
   logic [63:0] srcaddr_reg;
   logic [63:0] dstaddr_reg;
   logic [15:0] status_hi;        // sw field of status
   dma_state_t  status_state;
   logic [31:0] status_reg;
   reg_sel_t    sel;
   logic        reg_write;
   logic        reg_read;
   logic [31:0] rd_data;
   logic [`EDMA_AW-1:0] wdata;

   // ####################
   // decode
   assign sel       = reg_sel_t'(reg_packet_in.dstaddr[6:2]);
   assign wdata     = reg_packet_in.data;
   assign reg_write = reg_access_in & reg_packet_in.write;
   assign reg_read  = reg_access_in & ~reg_packet_in.write;

   // ####################
   // config
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         config_reg <= '0;
      end else if (reg_write && sel == REG_CONFIG) begin
         config_reg <= wdata;
      end else if (cfg.done) begin
         config_reg[`EDMA_CFG_EN] <= 1'b0;   // transfer finished
      end
   end

   // launch only from idle
   assign cfg.start = reg_write & (sel == REG_CONFIG) & wdata[`EDMA_CFG_EN]
                      & (cfg.state == IDLE);

   assign cfg.enable   = config_reg[`EDMA_CFG_EN];
   assign cfg.irqmode  = config_reg[`EDMA_CFG_IRQ];
   assign cfg.datamode = config_reg[`EDMA_CFG_DMODE];

   // ####################
   // datapath registers
   always_ff @(posedge clk) begin
      if (reg_write && sel == REG_STRIDE)
         stride_reg <= wdata;
   end

   always_ff @(posedge clk) begin
      if (reg_write && sel == REG_COUNT)
         count_reg <= wdata;
      else if (cfg.update)
         count_reg <= cfg.cur_count;      // remaining count
   end

   always_ff @(posedge clk) begin
      if (reg_write && sel == REG_SRCADDR)
         srcaddr_reg[31:0] <= wdata;
      else if (cfg.update)
         srcaddr_reg[`EDMA_AW-1:0] <= cfg.cur_srcaddr;
      if (reg_write && sel == REG_SRCADDR64)
         srcaddr_reg[63:32] <= wdata;      // high word only stored
   end

   always_ff @(posedge clk) begin
      if (reg_write && sel == REG_DSTADDR)
         dstaddr_reg[31:0] <= wdata;
      else if (cfg.update)
         dstaddr_reg[`EDMA_AW-1:0] <= cfg.cur_dstaddr;
      if (reg_write && sel == REG_DSTADDR64)
         dstaddr_reg[63:32] <= wdata;
   end

   assign cfg.stride  = stride_reg[`EDMA_AW-1:0];
   assign cfg.count   = count_reg;
   assign cfg.srcaddr = srcaddr_reg[`EDMA_AW-1:0];
   assign cfg.dstaddr = dstaddr_reg[`EDMA_AW-1:0];

   // ####################
   // status, low nibble follows the sequencer
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         status_hi    <= '0;
         status_state <= IDLE;
      end else begin
         status_state <= cfg.state;
         if (reg_write && sel == REG_STATUS)
            status_hi <= wdata[31:16];
      end
   end

   assign status_reg = {status_hi, 12'b0, status_state};

   // ####################
   // readback
   always_comb begin
      case (sel)
         REG_CONFIG:    rd_data = config_reg;
         REG_STRIDE:    rd_data = stride_reg;
         REG_COUNT:     rd_data = count_reg;
         REG_SRCADDR:   rd_data = srcaddr_reg[31:0];
         REG_SRCADDR64: rd_data = srcaddr_reg[63:32];
         REG_DSTADDR:   rd_data = dstaddr_reg[31:0];
         REG_DSTADDR64: rd_data = dstaddr_reg[63:32];
         REG_STATUS:    rd_data = status_reg;
         default:       rd_data = '0;
      endcase
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         reg_access_out <= 1'b0;
      else
         reg_access_out <= reg_read;
   end

   // response payload, valid with reg_access_out
   always_ff @(posedge clk) begin
      if (reg_read) begin
         reg_packet_out.write    <= 1'b1;
         reg_packet_out.datamode <= reg_packet_in.datamode;
         reg_packet_out.ctrlmode <= reg_packet_in.ctrlmode;
         reg_packet_out.dstaddr  <= reg_packet_in.srcaddr;   // return address
         reg_packet_out.data     <= rd_data;
         reg_packet_out.srcaddr  <= reg_packet_in.dstaddr;   // register address
      end
   end

endmodule

// File: design/edma_engine.sv
/*
 * dma sequencer, manual mode only, one read request per cycle while credits last
 * request k reads src + k*stride and returns to dst + k*stride
 * clearing enable mid transfer goes through DRAIN, no wait for credits
 */
`timescale 1ns/1ps
`include "edma_consts.svh"

module edma_engine (
   input  logic                    clk,
   input  logic                    nreset,
   edma_cfg_if.engine              cfg,
   output logic                    dma_access_out,
   output edma_pkg::emesh_packet_t dma_packet_out,
   input  logic                    dma_credit_in,
   output logic                    irq
);
   import edma_pkg::*;

   dma_state_t          state_q;
   dma_state_t          state_d;
   logic [`EDMA_CRW-1:0] credits;
   logic [31:0]         work_count;
   logic [`EDMA_AW-1:0] work_src;
   logic [`EDMA_AW-1:0] work_dst;
   logic [31:0]         next_count;
   logic [`EDMA_AW-1:0] next_src;
   logic [`EDMA_AW-1:0] next_dst;
   logic                issue;
   logic                last;

   // ####################
   // issue decision
   assign issue = (state_q == ACTIVE) & cfg.enable & (credits != '0)
                  & (work_count != '0);
   assign last  = issue & (work_count == 32'd1);   // final request

   // stepped values
   assign next_count = work_count - 32'd1;
   assign next_src   = work_src + cfg.stride;
   assign next_dst   = work_dst + cfg.stride;

   // ####################
   // fsm
   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (cfg.start)
               state_d = ACTIVE;
         end
         ACTIVE: begin
            if (!cfg.enable)
               state_d = DRAIN;                 // aborted by sw
            else if (work_count == '0 || last)
               state_d = DONE;
         end
         DRAIN:   state_d = DONE;
         DONE:    state_d = IDLE;                // done pulse here
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         state_q <= IDLE;
      else
         state_q <= state_d;
   end

   // working count and addresses
   always_ff @(posedge clk) begin
      if (cfg.start && state_q == IDLE) begin
         work_count <= cfg.count;
         work_src   <= cfg.srcaddr;
         work_dst   <= cfg.dstaddr;
      end else if (issue) begin
         work_count <= next_count;
         work_src   <= next_src;
         work_dst   <= next_dst;
      end
   end

   // ####################
   // credits, spend and return cancel
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         credits <= `EDMA_CRW'(`EDMA_CREDITS);
      end else begin
         case ({issue, dma_credit_in})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
      end
   end

   // ####################
   // request packet
   always_comb begin
      dma_packet_out          = '0;
      dma_packet_out.write    = 1'b0;          // read request
      dma_packet_out.datamode = cfg.datamode;
      dma_packet_out.dstaddr  = work_src;      // read from source
      dma_packet_out.srcaddr  = work_dst;      // data lands at destination
   end

   assign dma_access_out = issue;

   // write-back, values after the step
   assign cfg.update      = issue;
   assign cfg.cur_count   = next_count;
   assign cfg.cur_srcaddr = next_src;
   assign cfg.cur_dstaddr = next_dst;
   assign cfg.state       = state_q;
   assign cfg.done        = (state_q == DONE);

   assign irq = (state_q == DONE) & cfg.irqmode;   // one cycle

endmodule

// File: design/edma.sv
/*
 * dma top, config port never stalls
 * master port uses credits, receiver must return one per request
 */
`timescale 1ns/1ps

module edma (
   input  logic                    clk,
   input  logic                    nreset,
   // config in
   input  logic                    reg_access_in,
   input  edma_pkg::emesh_packet_t reg_packet_in,
   // readback out
   output logic                    reg_access_out,
   output edma_pkg::emesh_packet_t reg_packet_out,
   // master port
   output logic                    dma_access_out,
   output edma_pkg::emesh_packet_t dma_packet_out,
   input  logic                    dma_credit_in,
   output logic                    irq
);

   edma_cfg_if cfg_if ();   // regs <-> engine

   edma_regs u_regs (
      .clk            (clk),
      .nreset         (nreset),
      .reg_access_in  (reg_access_in),
      .reg_packet_in  (reg_packet_in),
      .reg_access_out (reg_access_out),
      .reg_packet_out (reg_packet_out),
      .cfg            (cfg_if.regs)
   );

   edma_engine u_engine (
      .clk            (clk),
      .nreset         (nreset),
      .cfg            (cfg_if.engine),
      .dma_access_out (dma_access_out),
      .dma_packet_out (dma_packet_out),
      .dma_credit_in  (dma_credit_in),
      .irq            (irq)
   );

endmodule

// File: sim/edma_assert.sv
/*
 * protocol checks, one copy bound into the engine and one into the top level
 * inputs that a copy does not watch are tied low
 * fails counts assertion failures for the end of the run
 */
`timescale 1ns/1ps
`include "edma_consts.svh"

module edma_assert (
   input logic                 clk,
   input logic                 nreset,
   input logic                 req,        // dma_access_out
   input logic                 credit_ret, // dma_credit_in
   input logic [`EDMA_CRW-1:0] credits,
   input logic                 irq,
   input logic                 rd_req,     // read packet at the config port
   input logic                 rd_resp     // reg_access_out
);

   int                   fails = 0;
   logic [`EDMA_CRW-1:0] port_credits;   // credits as seen at the master port

   // ####################
   // credit model from port traffic only
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         port_credits <= `EDMA_CRW'(`EDMA_CREDITS);
      else
         port_credits <= port_credits - `EDMA_CRW'(req) + `EDMA_CRW'(credit_ret);
   end

   // never issue on an empty credit counter
   a_credit_avail: assert property (@(posedge clk) disable iff (!nreset)
      req |-> port_credits != '0)
      else begin
         $error("request issued with no credit left");
         fails++;
      end

   // irq is a single-cycle pulse
   a_irq_pulse: assert property (@(posedge clk) disable iff (!nreset)
      irq |=> !irq)
      else begin
         $error("irq held for more than one cycle");
         fails++;
      end

   // readback exactly one cycle after each read, and only then
   a_rd_resp: assert property (@(posedge clk) disable iff (!nreset)
      rd_req |=> rd_resp)
      else begin
         $error("read packet got no response one cycle later");
         fails++;
      end
   a_rd_quiet: assert property (@(posedge clk) disable iff (!nreset)
      !rd_req |=> !rd_resp)
      else begin
         $error("readback without a read one cycle earlier");
         fails++;
      end

   a_credit_max: assert property (@(posedge clk) disable iff (!nreset)
      credits <= `EDMA_CREDITS)
      else begin
         $error("credit counter above its reset value");
         fails++;
      end

endmodule

bind edma_engine edma_assert u_engine_chk (
   .clk(clk), .nreset(nreset), .req(dma_access_out), .credit_ret(dma_credit_in),
   .credits(credits), .irq(irq), .rd_req(1'b0), .rd_resp(1'b0)
);

bind edma edma_assert u_top_chk (
   .clk(clk), .nreset(nreset), .req(1'b0), .credit_ret(1'b0),
   .credits(`EDMA_CRW'(0)), .irq(1'b0),
   .rd_req(reg_access_in & ~reg_packet_in.write), .rd_resp(reg_access_out)
);

// File: sim/tb_edma.sv
/*
 * testbench for edma, strides, counts and addresses from a 16-bit lfsr (seed 27)
 * the receiver model returns one credit per request after a random delay
 * every wait is bounded, a stalled DUT shows up in the timeout count
 */
`timescale 1ns/1ps
`include "edma_consts.svh"

module tb_edma;
   import edma_pkg::*;

   localparam int RD_TMO   = 16;    // cycles for one readback
   localparam int POLL_TMO = 200;   // register polls
   localparam int REQ_TMO  = 200;   // cycles waiting for requests

   logic          clk           = 1'b0;
   logic          nreset        = 1'b0;
   logic          reg_access_in = 1'b0;
   emesh_packet_t reg_packet_in = '0;
   logic          dma_credit_in = 1'b0;
   logic          reg_access_out;
   emesh_packet_t reg_packet_out;
   logic          dma_access_out;
   emesh_packet_t dma_packet_out;
   logic          irq;

   // programmed transfer, written by the main sequence
   logic [31:0] prog_stride;
   logic [31:0] prog_src;
   logic [31:0] prog_dst;
   logic [31:0] src_hi;
   logic [31:0] dst_hi;
   logic [1:0]  prog_dmode;
   logic [31:0] cfg_word;
   int          prog_count  = 0;
   int          xfer_base   = 0;       // req_count at start of transfer
   int          irq_base    = 0;
   logic        slow_credit = 1'b0;
   int          errors      = 0;
   int          timeouts    = 0;
   logic [15:0] stim_lfsr   = 16'd27;

   // comparing process
   int          req_count     = 0;
   int          irq_count     = 0;
   int          outstanding   = 0;     // requests not yet credited
   int          stream_errors = 0;

   // receiver model
   logic [15:0] credit_lfsr = 16'd27;
   logic [31:0] delay;
   int          owed = 0;
   int          hold = 0;

   logic [4:0]  rw_regs [6] = '{`EDMA_STRIDE, `EDMA_COUNT, `EDMA_SRCADDR,
                                `EDMA_SRCADDR64, `EDMA_DSTADDR, `EDMA_DSTADDR64};

   edma DUT (
      .clk            (clk),
      .nreset         (nreset),
      .reg_access_in  (reg_access_in),
      .reg_packet_in  (reg_packet_in),
      .reg_access_out (reg_access_out),
      .reg_packet_out (reg_packet_out),
      .dma_access_out (dma_access_out),
      .dma_packet_out (dma_packet_out),
      .dma_credit_in  (dma_credit_in),
      .irq            (irq)
   );

   always #4 clk = ~clk;   // 8 ns period

   // ####################
   // helpers
   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic rand_bits(inout logic [15:0] st, input int n, output logic [31:0] value);
      value = '0;
      for (int i = 0; i < n; i++) begin
         st    = lfsr_next(st);     // one step per bit
         value = {value[30:0], st[0]};
      end
   endtask

   // request k: read src + k*stride, land at dst + k*stride
   function automatic emesh_packet_t ref_request(input int k);
      emesh_packet_t p;
      p          = '0;
      p.write    = 1'b0;
      p.datamode = prog_dmode;
      p.dstaddr  = prog_src + 32'(k) * prog_stride;
      p.srcaddr  = prog_dst + 32'(k) * prog_stride;
      return p;
   endfunction

   function automatic int check_val(input string name, input logic [`EDMA_PW-1:0] exp,
                                    input logic [`EDMA_PW-1:0] act);
      int bad;
      bad = 0;
      assert (exp === act) else begin
         $display("CHECK FAILED at %0t: %s expected %0h actual %0h", $time, name, exp, act);
         bad = 1;
      end
      return bad;
   endfunction

   // tasks start right after a rising edge
   task automatic reg_write(input logic [4:0] idx, input logic [31:0] value);
      emesh_packet_t p;
      p         = '0;
      p.write   = 1'b1;
      p.dstaddr = {25'b0, idx, 2'b00};
      p.data    = value;
      reg_access_in <= 1'b1;
      reg_packet_in <= p;
      @(posedge clk);
      reg_access_in <= 1'b0;
   endtask

   task automatic reg_read(input logic [4:0] idx, output logic [31:0] value);
      emesh_packet_t p;
      int n;
      p         = '0;
      p.dstaddr = {25'b0, idx, 2'b00};
      p.srcaddr = 32'h8000_0000 | 32'(idx);   // return address
      reg_access_in <= 1'b1;
      reg_packet_in <= p;
      @(posedge clk);
      reg_access_in <= 1'b0;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (!reg_access_out && n < RD_TMO);
      if (!reg_access_out) begin
         $display("timeout: no readback for register index %0d", idx);
         timeouts++;
      end
      errors += check_val("readback latency", 1, n);
      errors += check_val("reg_packet_out.write", 1, reg_packet_out.write);
      errors += check_val("reg_packet_out.dstaddr", p.srcaddr, reg_packet_out.dstaddr);
      value = reg_packet_out.data;
   endtask

   task automatic read_check(input logic [4:0] idx, input logic [31:0] exp, input string name);
      logic [31:0] v;
      reg_read(idx, v);
      errors += check_val(name, exp, v);
   endtask

   task automatic wait_reg_bits(input logic [4:0] idx, input logic [31:0] mask,
                                input logic [31:0] want, input string what);
      logic [31:0] v;
      int polls;
      polls = 0;
      do begin
         reg_read(idx, v);
         polls++;
      end while ((v & mask) !== want && polls < POLL_TMO);
      if ((v & mask) !== want) begin
         $display("timeout: %s, register %0d never reached %0h", what, idx, want);
         timeouts++;
      end
   endtask

   // count 0 draws a random count of 1..12
   task automatic load_transfer(input int count);
      logic [31:0] r;
      rand_bits(stim_lfsr, 8, r);
      prog_stride = r << 2;               // word steps
      rand_bits(stim_lfsr, 4, r);
      prog_count = (count > 0) ? count : int'(r % 12) + 1;
      rand_bits(stim_lfsr, 32, prog_src);
      rand_bits(stim_lfsr, 32, prog_dst);
      rand_bits(stim_lfsr, 32, src_hi);
      rand_bits(stim_lfsr, 32, dst_hi);
      rand_bits(stim_lfsr, 2, r);
      prog_dmode = r[1:0];
      reg_write(`EDMA_STRIDE, prog_stride);
      reg_write(`EDMA_COUNT, 32'(prog_count));
      reg_write(`EDMA_SRCADDR, prog_src);
      reg_write(`EDMA_SRCADDR64, src_hi);
      reg_write(`EDMA_DSTADDR, prog_dst);
      reg_write(`EDMA_DSTADDR64, dst_hi);
   endtask

   task automatic start_transfer(input logic irqmode);
      cfg_word  = 32'd1 | (32'(irqmode) << `EDMA_CFG_IRQ) | (32'(prog_dmode) << 5);
      xfer_base = req_count;
      irq_base  = irq_count;
      reg_write(`EDMA_CONFIG, cfg_word);   // enable set, engine starts
   endtask

   task automatic check_progress(input logic irqmode);
      logic [31:0] span;
      span = 32'(prog_count) * prog_stride;
      errors += check_val("dma_access_out count", prog_count, req_count - xfer_base);
      errors += check_val("irq pulses", irqmode, irq_count - irq_base);
      read_check(`EDMA_COUNT, 32'd0, "count register");
      read_check(`EDMA_SRCADDR, prog_src + span, "srcaddr low");
      read_check(`EDMA_SRCADDR64, src_hi, "srcaddr high");
      read_check(`EDMA_DSTADDR, prog_dst + span, "dstaddr low");
      read_check(`EDMA_DSTADDR64, dst_hi, "dstaddr high");
      read_check(`EDMA_CONFIG, cfg_word & ~32'd1, "config register");
   endtask

   task automatic finish_run();
      int assert_fails;
      assert_fails = DUT.u_engine.u_engine_chk.fails + DUT.u_top_chk.fails;
      $display("errors: %0d register, %0d stream, %0d timeouts, %0d assertions",
               errors, stream_errors, timeouts, assert_fails);
      if (errors == 0 && stream_errors == 0 && timeouts == 0 && assert_fails == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   endtask

   // ####################
   // receiver, one credit back per request
   always @(posedge clk) begin
      if (!nreset) begin
         owed = 0;
         hold = 0;
         dma_credit_in <= 1'b0;
      end else begin
         if (dma_access_out)
            owed = owed + 1;
         if (owed > 0 && hold == 0) begin
            dma_credit_in <= 1'b1;
            owed = owed - 1;
            rand_bits(credit_lfsr, 2, delay);    // 0..3 cycles
            hold = slow_credit ? int'(delay) + 4 : int'(delay);
         end else begin
            dma_credit_in <= 1'b0;
            if (hold > 0)
               hold = hold - 1;
         end
      end
   end

   // ####################
   // compare the request stream
   always @(posedge clk) begin
      if (nreset) begin
         if (dma_access_out) begin
            assert (req_count - xfer_base < prog_count) else begin
               stream_errors++;
               $display("request at %0t beyond the programmed count %0d", $time, prog_count);
            end
            stream_errors += check_val("dma_packet_out", ref_request(req_count - xfer_base),
                                       dma_packet_out);
            req_count++;
            outstanding++;
         end
         if (dma_credit_in)
            outstanding--;
         assert (outstanding <= `EDMA_CREDITS) else begin
            stream_errors++;
            $display("CHECK FAILED at %0t: outstanding expected <= %0d actual %0d",
                     $time, `EDMA_CREDITS, outstanding);
         end
         if (irq) begin
            irq_count++;
            assert (req_count - xfer_base == prog_count) else begin
               stream_errors++;
               $display("irq at %0t before the last request", $time);
            end
         end
      end
   end

   // ####################
   // main sequence
   initial begin
      logic [31:0] r;
      logic [31:0] v;
      int          n;
      repeat (8) @(posedge clk);
      nreset <= 1'b1;
      @(posedge clk);

      // write then read back each datapath register
      for (int i = 0; i < 6; i++) begin
         rand_bits(stim_lfsr, 32, r);
         reg_write(rw_regs[i], r);
         read_check(rw_regs[i], r, "reg_packet_out.data");
      end
      read_check(5'd12, 32'd0, "unmapped register");

      // bit 0 irqmode, bit 1 slow credit return
      for (int t = 0; t < 4; t++) begin
         slow_credit <= t[1];
         load_transfer(0);
         start_transfer(t[0]);
         wait_reg_bits(`EDMA_CONFIG, 32'h1, 32'h0, "transfer end");
         check_progress(t[0]);
      end

      // abort mid transfer
      slow_credit <= 1'b1;
      load_transfer(12);
      start_transfer(1'b0);
      n = 0;
      while (req_count - xfer_base < 3 && n < REQ_TMO) begin
         @(posedge clk);
         n++;
      end
      if (req_count - xfer_base < 3) begin
         $display("timeout: transfer issued too few requests before the abort");
         timeouts++;
      end
      reg_write(`EDMA_CONFIG, 32'd0);
      wait_reg_bits(`EDMA_STATUS, 32'hf, 32'h0, "abort drain to idle");
      reg_read(`EDMA_COUNT, v);
      errors += check_val("requests plus remaining count", 12, req_count - xfer_base + int'(v));
      finish_run();
   end

endmodule

// File: Makefile
# Verilator build and run of the edma testbench
VERILATOR ?= verilator
TOP       ?= tb_edma
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FLIST)) $(wildcard design/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "simulation FAILED, see $(LOG)"; exit 1; fi
	@if ! grep -q "All tests passed!" $(LOG); then echo "simulation ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: flist.f
+incdir+design
design/edma_pkg.sv
design/edma_cfg_if.sv
design/edma_regs.sv
design/edma_engine.sv
design/edma.sv
sim/edma_assert.sv
sim/tb_edma.sv
